// ==== clock_defs.svh ====
`ifndef CLOCK_DEFS_SVH
`define CLOCK_DEFS_SVH

//////////////////////////////
// Time limits
//////////////////////////////

// Largest hour in 12-hour form, smallest is 1
`define HOUR_MAX 12

// Shared limit for minutes and seconds
`define MIN_MAX 59

// Clock cycles per second at 100 MHz
`define TICK_DIV_DEFAULT 100000000

`endif

// ==== clock_pkg.sv ====
`default_nettype none

package clock_pkg;

        // Binary time fields
        typedef logic [3:0] hour_t;
        typedef logic [5:0] min_t;
        typedef logic [5:0] sec_t;

        // One decimal digit
        typedef logic [3:0] bcd_t;

        // Alarm ring FSM
        typedef enum logic [1:0] {
                ring_idle,
                ring_active,
                ring_done
        } ring_state_t;

endpackage

`default_nettype wire

// ==== tick_gen.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "clock_defs.svh"

module tick_gen #(
        parameter int tick_div = `TICK_DIV_DEFAULT
) (
        input  logic clk,
        input  logic reset,
        output logic tick
);

        localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

        logic [cnt_w-1:0] cnt;

        // Down-counter, reload on zero
        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        cnt  <= cnt_w'(tick_div - 1);
                        tick <= 1'b0;
                end else if (cnt == '0) begin
                        cnt  <= cnt_w'(tick_div - 1);
                        tick <= 1'b1;
                end else begin
                        cnt  <= cnt - 1'b1;
                        tick <= 1'b0;
                end
        end

        // Single-cycle pulse when the divider is real
        a_tick_one_cycle: assert property (
                @(posedge clk) disable iff (reset)
                (tick_div > 1) && tick |=> !tick
        ) else $error("tick high for two cycles in a row");

endmodule

`default_nettype wire

// ==== time_keeper.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "clock_defs.svh"

module time_keeper (
        input  logic             clk,
        input  logic             reset,
        input  logic             tick,
        input  logic             set_valid,
        input  clock_pkg::hour_t set_hour,
        input  clock_pkg::min_t  set_min,
        input  clock_pkg::sec_t  set_sec,
        input  logic             set_pm,
        output logic             set_ready,
        output logic             set_err,
        output clock_pkg::hour_t cur_hour,
        output clock_pkg::min_t  cur_min,
        output clock_pkg::sec_t  cur_sec,
        output logic             cur_pm,
        output logic             am_pm,
        output logic             end_of_day,
        output clock_pkg::bcd_t  sec_1d,
        output clock_pkg::bcd_t  sec_10d,
        output clock_pkg::bcd_t  min_1d,
        output clock_pkg::bcd_t  min_10d,
        output clock_pkg::bcd_t  hour_1d,
        output clock_pkg::bcd_t  hour_10d
);

        import clock_pkg::*;

        hour_t r_hour;
        min_t  r_min;
        sec_t  r_sec;
        logic  r_pm;     // am = 0, pm = 1
        logic  ready_en;
        logic  set_fire;
        logic  set_ok;
        logic  set_load;
        logic  sec_wrap;
        logic  min_wrap;
        logic  pm_flip;

        //////////////////////////////
        // Set port
        //////////////////////////////

        // Never ready on a tick cycle
        assign set_ready = ready_en && !tick;
        assign set_fire  = set_valid && set_ready;
        assign set_ok    = (set_hour != '0) && (set_hour <= hour_t'(`HOUR_MAX)) &&
                           (set_min <= min_t'(`MIN_MAX)) && (set_sec <= sec_t'(`MIN_MAX));
        assign set_load  = set_fire && set_ok;

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        ready_en <= 1'b0;
                        set_err  <= 1'b0;
                end else begin
                        ready_en <= 1'b1;
                        set_err  <= set_fire && !set_ok;
                end
        end

        //////////////////////////////
        // Counters
        //////////////////////////////

        assign sec_wrap = (r_sec == sec_t'(`MIN_MAX));
        assign min_wrap = sec_wrap && (r_min == min_t'(`MIN_MAX));
        assign pm_flip  = min_wrap && (r_hour == hour_t'(`HOUR_MAX - 1));

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        r_sec  <= '0;
                        r_min  <= '0;
                        r_hour <= hour_t'(`HOUR_MAX);
                        r_pm   <= 1'b0;
                end else if (set_load) begin
                        r_sec  <= set_sec;
                        r_min  <= set_min;
                        r_hour <= set_hour;
                        r_pm   <= set_pm;
                end else if (tick) begin
                        r_sec <= sec_wrap ? '0 : r_sec + 1'b1;
                        if (sec_wrap) begin
                                r_min <= (r_min == min_t'(`MIN_MAX)) ? '0 : r_min + 1'b1;
                        end
                        // Hour 12 rolls over to 1
                        if (min_wrap) begin
                                r_hour <= (r_hour == hour_t'(`HOUR_MAX)) ? hour_t'(1) :
                                          r_hour + 1'b1;
                        end
                        if (pm_flip) begin
                                r_pm <= !r_pm;
                        end
                end
        end

        assign end_of_day = pm_flip && r_pm;
        assign am_pm      = r_pm;
        assign cur_hour   = r_hour;
        assign cur_min    = r_min;
        assign cur_sec    = r_sec;
        assign cur_pm     = r_pm;

        // Binary to BCD digits
        assign sec_1d   = bcd_t'(r_sec % 10);
        assign sec_10d  = bcd_t'(r_sec / 10);
        assign min_1d   = bcd_t'(r_min % 10);
        assign min_10d  = bcd_t'(r_min / 10);
        assign hour_1d  = bcd_t'(r_hour % 10);
        assign hour_10d = bcd_t'(r_hour / 10);

        a_hour_range: assert property (@(posedge clk) disable iff (reset)
                (r_hour >= hour_t'(1)) && (r_hour <= hour_t'(`HOUR_MAX)))
                else $error("hour out of range");

        a_min_sec_range: assert property (@(posedge clk) disable iff (reset)
                (r_min <= min_t'(`MIN_MAX)) && (r_sec <= sec_t'(`MIN_MAX)))
                else $error("minute or second out of range");

endmodule

`default_nettype wire

// ==== alarm_store.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "clock_defs.svh"

module alarm_store (
        input  logic             clk,
        input  logic             reset,
        input  logic             alarm_valid,
        input  clock_pkg::hour_t alarm_hour,
        input  clock_pkg::min_t  alarm_min,
        input  logic             alarm_pm,
        input  logic             alarm_enable,
        output logic             alarm_ready,
        output logic             alarm_err,
        output clock_pkg::hour_t al_hour,
        output clock_pkg::min_t  al_min,
        output logic             al_pm,
        output logic             al_enable
);

        import clock_pkg::*;

        logic wr_fire;
        logic wr_ok;

        assign wr_fire = alarm_valid && alarm_ready;
        assign wr_ok   = (alarm_hour != '0) && (alarm_hour <= hour_t'(`HOUR_MAX)) &&
                         (alarm_min <= min_t'(`MIN_MAX));

        // Ready from the first cycle after reset
        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        alarm_ready <= 1'b0;
                        alarm_err   <= 1'b0;
                end else begin
                        alarm_ready <= 1'b1;
                        alarm_err   <= wr_fire && !wr_ok;
                end
        end

        // Bad writes keep the old alarm
        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        al_hour   <= hour_t'(`HOUR_MAX);
                        al_min    <= '0;
                        al_pm     <= 1'b0;
                        al_enable <= 1'b0;
                end else if (wr_fire && wr_ok) begin
                        al_hour   <= alarm_hour;
                        al_min    <= alarm_min;
                        al_pm     <= alarm_pm;
                        al_enable <= alarm_enable;
                end
        end

endmodule

`default_nettype wire

// ==== alarm_match.sv ====
`default_nettype none
`timescale 1ns/10ps

module alarm_match (
        input  logic             clk,
        input  logic             reset,
        input  clock_pkg::hour_t cur_hour,
        input  clock_pkg::min_t  cur_min,
        input  clock_pkg::sec_t  cur_sec,
        input  logic             cur_pm,
        input  clock_pkg::hour_t al_hour,
        input  clock_pkg::min_t  al_min,
        input  logic             al_pm,
        input  logic             al_enable,
        input  logic             ring_ack,
        output logic             ring
);

        import clock_pkg::*;

        ring_state_t state;
        ring_state_t state_nxt;
        logic        match;

        // Only second 0 of the alarm minute counts
        assign match = al_enable && (cur_hour == al_hour) && (cur_min == al_min) &&
                       (cur_pm == al_pm) && (cur_sec == '0);

        always_comb begin
                state_nxt = state;
                case (state)
                        ring_idle:   if (match) state_nxt = ring_active;
                        ring_active: if (ring_ack) state_nxt = ring_done;
                        // Re-arm once the matching second is gone
                        ring_done:   if (!match) state_nxt = ring_idle;
                        default:     state_nxt = ring_idle;
                endcase
        end

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        state <= ring_idle;
                        ring  <= 1'b0;
                end else begin
                        state <= state_nxt;
                        ring  <= (state_nxt == ring_active);
                end
        end

        a_ring_state: assert property (@(posedge clk) disable iff (reset)
                ring == (state == ring_active))
                else $error("ring out of step with the FSM");

endmodule

`default_nettype wire

// ==== clock_top.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "clock_defs.svh"

module clock_top #(
        parameter int tick_div = `TICK_DIV_DEFAULT
) (
        input  logic             clk,
        input  logic             reset,
        input  logic             set_valid,
        output logic             set_ready,
        input  clock_pkg::hour_t set_hour,
        input  clock_pkg::min_t  set_min,
        input  clock_pkg::sec_t  set_sec,
        input  logic             set_pm,
        input  logic             alarm_valid,
        output logic             alarm_ready,
        input  clock_pkg::hour_t alarm_hour,
        input  clock_pkg::min_t  alarm_min,
        input  logic             alarm_pm,
        input  logic             alarm_enable,
        output logic             set_err,
        output logic             alarm_err,
        output logic             ring,
        input  logic             ring_ack,
        output clock_pkg::bcd_t  sec_1d,
        output clock_pkg::bcd_t  sec_10d,
        output clock_pkg::bcd_t  min_1d,
        output clock_pkg::bcd_t  min_10d,
        output clock_pkg::bcd_t  hour_1d,
        output clock_pkg::bcd_t  hour_10d,
        output logic             am_pm,
        output logic             end_of_day
);

        import clock_pkg::*;

        logic  tick;
        hour_t cur_hour;
        min_t  cur_min;
        sec_t  cur_sec;
        logic  cur_pm;
        hour_t al_hour;
        min_t  al_min;
        logic  al_pm;
        logic  al_enable;

        //////////////////////////////
        // Time base and counter
        //////////////////////////////

        tick_gen #(.tick_div(tick_div)) i_tick_gen (.clk, .reset, .tick);

        time_keeper i_time_keeper (
                .clk, .reset, .tick,
                .set_valid, .set_hour, .set_min, .set_sec, .set_pm, .set_ready, .set_err,
                .cur_hour, .cur_min, .cur_sec, .cur_pm, .am_pm, .end_of_day,
                .sec_1d, .sec_10d, .min_1d, .min_10d, .hour_1d, .hour_10d
        );

        //////////////////////////////
        // Alarm
        //////////////////////////////

        alarm_store i_alarm_store (
                .clk, .reset,
                .alarm_valid, .alarm_hour, .alarm_min, .alarm_pm, .alarm_enable,
                .alarm_ready, .alarm_err, .al_hour, .al_min, .al_pm, .al_enable
        );

        alarm_match i_alarm_match (
                .clk, .reset,
                .cur_hour, .cur_min, .cur_sec, .cur_pm,
                .al_hour, .al_min, .al_pm, .al_enable, .ring_ack, .ring
        );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_clk_gen #(
        parameter int half_period  = 5,
        parameter int reset_cycles = 3
) (
        output logic clk,
        output logic reset
);

        initial begin
                clk = 1'b0;
                forever #(half_period) clk = ~clk;
        end

        // Reset released on a rising edge
        initial begin
                reset = 1'b1;
                repeat (reset_cycles) @(posedge clk);
                reset <= 1'b0;
        end

endmodule

`default_nettype wire

// ==== tb_clock_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_clock_top;

        import clock_pkg::*;

        logic  clk;
        logic  reset;
        logic  set_valid;
        logic  set_ready;
        hour_t set_hour;
        min_t  set_min;
        sec_t  set_sec;
        logic  set_pm;
        logic  set_err;
        logic  alarm_valid;
        logic  alarm_ready;
        hour_t alarm_hour;
        min_t  alarm_min;
        logic  alarm_pm;
        logic  alarm_enable;
        logic  alarm_err;
        logic  ring;
        logic  ring_ack;
        bcd_t  sec_1d;
        bcd_t  sec_10d;
        bcd_t  min_1d;
        bcd_t  min_10d;
        bcd_t  hour_1d;
        bcd_t  hour_10d;
        logic  am_pm;
        logic  end_of_day;

        // Reference time model
        hour_t m_hour;
        min_t  m_min;
        sec_t  m_sec;
        logic  m_pm;
        int    errors;
        int    checks;

        tb_clk_gen i_clk_gen (.clk, .reset);

        clock_top #(.tick_div(4)) i_dut (.*);

        //////////////////////////////
        // Checks and model
        //////////////////////////////

        task automatic check_bit(string name, logic got, logic exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("[ERROR] %0t: %s is %b, expected %b", $time, name, got, exp);
                end
        endtask

        task automatic check_time();
                logic exp_eod;
                exp_eod = m_pm && (m_hour == 4'd11) && (m_min == 6'd59) && (m_sec == 6'd59);
                checks++;
                if ({hour_10d, hour_1d, min_10d, min_1d, sec_10d, sec_1d} !==
                    {bcd_t'(m_hour / 10), bcd_t'(m_hour % 10), bcd_t'(m_min / 10),
                     bcd_t'(m_min % 10), bcd_t'(m_sec / 10), bcd_t'(m_sec % 10)} ||
                    am_pm !== m_pm || end_of_day !== exp_eod) begin
                        errors++;
                        $write("[ERROR] %0t: time %0d%0d:%0d%0d:%0d%0d pm %b eod %b, ",
                               $time, hour_10d, hour_1d, min_10d, min_1d, sec_10d, sec_1d,
                               am_pm, end_of_day);
                        $display("expected %0d:%0d:%0d pm %b eod %b",
                                 m_hour, m_min, m_sec, m_pm, exp_eod);
                end
        endtask

        // One second of the 12-hour count
        task automatic step_model();
                if (m_sec != 6'd59) begin
                        m_sec = m_sec + 1'b1;
                end else begin
                        m_sec = '0;
                        if (m_min != 6'd59) begin
                                m_min = m_min + 1'b1;
                        end else begin
                                m_min = '0;
                                if (m_hour == 4'd11) begin
                                        m_pm = !m_pm;
                                end
                                m_hour = (m_hour == 4'd12) ? 4'd1 : m_hour + 1'b1;
                        end
                end
        endtask

        task automatic report(string name, int e0);
                $display("Test %s: %s, %0d errors", name, (errors == e0) ? "ok" : "failed",
                         errors - e0);
        endtask

        //////////////////////////////
        // Bus drivers and waits
        //////////////////////////////

        // Wait for the seconds to move, then follow with the model
        task automatic wait_tick();
                bcd_t last;
                int   n;
                last = sec_1d;
                n = 0;
                while (sec_1d == last && n < 20) begin
                        @(negedge clk);
                        n++;
                end
                if (sec_1d == last) begin
                        errors++;
                        $display("Timeout at %0t: the seconds never advanced", $time);
                end
                step_model();
                check_time();
        endtask

        task automatic do_set(int h, int mi, int s, logic pm, logic bad);
                int n;
                @(posedge clk);
                set_valid <= 1'b1;
                set_hour  <= hour_t'(h);
                set_min   <= min_t'(mi);
                set_sec   <= sec_t'(s);
                set_pm    <= pm;
                n = 0;
                @(negedge clk);
                while (!set_ready && n < 20) begin
                        @(negedge clk);
                        n++;
                end
                if (!set_ready) begin
                        errors++;
                        $display("Timeout at %0t: set_ready never went high", $time);
                end
                @(posedge clk);
                set_valid <= 1'b0;
                @(negedge clk);
                check_bit("set_err", set_err, bad);
                if (!bad) begin
                        m_hour = hour_t'(h);
                        m_min  = min_t'(mi);
                        m_sec  = sec_t'(s);
                        m_pm   = pm;
                end
                check_time();
        endtask

        task automatic do_alarm(int h, int mi, logic pm, logic en, logic bad);
                int n;
                @(posedge clk);
                alarm_valid  <= 1'b1;
                alarm_hour   <= hour_t'(h);
                alarm_min    <= min_t'(mi);
                alarm_pm     <= pm;
                alarm_enable <= en;
                n = 0;
                @(negedge clk);
                while (!alarm_ready && n < 20) begin
                        @(negedge clk);
                        n++;
                end
                if (!alarm_ready) begin
                        errors++;
                        $display("Timeout at %0t: alarm_ready never went high", $time);
                end
                @(posedge clk);
                alarm_valid <= 1'b0;
                @(negedge clk);
                check_bit("alarm_err", alarm_err, bad);
        endtask

        task automatic wait_ring();
                int n;
                n = 0;
                while (!ring && n < 10) begin
                        @(negedge clk);
                        n++;
                end
                if (!ring) begin
                        errors++;
                        $display("Timeout at %0t: ring never rose", $time);
                end
        endtask

        task automatic ack_ring();
                @(posedge clk);
                ring_ack <= 1'b1;
                @(posedge clk);
                ring_ack <= 1'b0;
                @(negedge clk);
                check_bit("ring after ack", ring, 1'b0);
        endtask

        //////////////////////////////
        // Directed tests
        //////////////////////////////

        task automatic test_reset();
                int e0;
                int n;
                e0 = errors;
                n = 0;
                @(negedge clk);
                while (reset && n < 20) begin
                        @(negedge clk);
                        n++;
                end
                if (reset) begin
                        errors++;
                        $display("Reset was never released");
                end
                // Ready flags come up one edge later
                @(posedge clk);
                @(negedge clk);
                m_hour = 4'd12;
                m_min  = '0;
                m_sec  = '0;
                m_pm   = 1'b0;
                check_time();
                check_bit("ring", ring, 1'b0);
                check_bit("set_err", set_err, 1'b0);
                check_bit("alarm_err", alarm_err, 1'b0);
                check_bit("set_ready", set_ready, 1'b1);
                check_bit("alarm_ready", alarm_ready, 1'b1);
                report("reset", e0);
        endtask

        task automatic test_counting();
                int e0;
                e0 = errors;
                do_set(3, 58, 57, 1'b0, 1'b0);
                repeat (10) wait_tick();
                report("counting", e0);
        endtask

        task automatic test_rollover();
                int e0;
                e0 = errors;
                do_set(12, 59, 59, 1'b0, 1'b0);
                wait_tick();
                do_set(11, 59, 59, 1'b0, 1'b0);
                wait_tick();
                do_set(11, 59, 59, 1'b1, 1'b0);
                wait_tick();
                report("rollover", e0);
        endtask

        // Bad sets go right after a count, clear of the next tick
        task automatic test_reject();
                int e0;
                e0 = errors;
                do_set(5, 10, 20, 1'b1, 1'b0);
                wait_tick();
                do_set(13, 0, 0, 1'b0, 1'b1);
                wait_tick();
                do_set(4, 60, 0, 1'b0, 1'b1);
                wait_tick();
                report("reject", e0);
        endtask

        task automatic test_alarm();
                int e0;
                e0 = errors;
                do_alarm(7, 31, 1'b1, 1'b1, 1'b0);
                do_set(7, 30, 58, 1'b1, 1'b0);
                wait_tick();
                wait_tick();
                // Ring follows the time by one cycle
                check_bit("ring at 7:31:00", ring, 1'b0);
                wait_ring();
                check_time();
                ack_ring();
                repeat (3) begin
                        wait_tick();
                        check_bit("ring after ack", ring, 1'b0);
                end
                // Same minute with the alarm disabled
                do_alarm(7, 31, 1'b1, 1'b0, 1'b0);
                do_set(7, 30, 58, 1'b1, 1'b0);
                repeat (3) begin
                        wait_tick();
                        @(negedge clk);
                        check_bit("disabled ring", ring, 1'b0);
                end
                do_alarm(8, 15, 1'b0, 1'b1, 1'b0);
                do_alarm(0, 15, 1'b0, 1'b1, 1'b1);
                do_set(8, 14, 59, 1'b0, 1'b0);
                wait_tick();
                wait_ring();
                check_time();
                ack_ring();
                report("alarm", e0);
        endtask

        initial begin
                set_valid    = 1'b0;
                set_hour     = '0;
                set_min      = '0;
                set_sec      = '0;
                set_pm       = 1'b0;
                alarm_valid  = 1'b0;
                alarm_hour   = '0;
                alarm_min    = '0;
                alarm_pm     = 1'b0;
                alarm_enable = 1'b0;
                ring_ack     = 1'b0;
                errors       = 0;
                checks       = 0;
                test_reset();
                test_counting();
                test_rollover();
                test_reject();
                test_alarm();
                $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
                if (errors == 0) begin
                        $display(">>> PASS");
                end else begin
                        $display(">>> FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
clock_pkg.sv
tick_gen.sv
time_keeper.sv
alarm_store.sv
alarm_match.sv
clock_top.sv
tb_clk_gen.sv
tb_clock_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the clock testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module tb_clock_top -Mdir obj_dir
./obj_dir/Vtb_clock_top > sim.log 2>&1 || true
cat sim.log
if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then
        echo "Simulation failed"
        exit 1
fi
echo "Simulation passed"
